//--- src/rv_pkg.sv
// rv_pkg: shared widths, instruction encodings and operation codes for the integer core
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // major opcodes of the supported groups
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_environ = 7'b1110011;

  localparam logic [6:0] f7_base   = 7'b0000000;
  localparam logic [6:0] f7_alt    = 7'b0100000;
  localparam logic [6:0] f7_muldiv = 7'b0000001;

  // funct3 of the base integer group, f3_add also covers sub and f3_sr both right shifts
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct3 of the divide half of the M group
  localparam logic [2:0] f3_div  = 3'b100;
  localparam logic [2:0] f3_divu = 3'b101;
  localparam logic [2:0] f3_rem  = 3'b110;
  localparam logic [2:0] f3_remu = 3'b111;

  typedef enum logic [4:0] {
    add_op, sub_op, sll_op, slt_op, sltu_op, xor_op, srl_op, sra_op, or_op, and_op,
    lui_op, divu_op, remu_op, div_op, rem_op, ecall_op, none_op
  } op_e;

  function automatic logic op_is_div(op_e op);
    return (op == divu_op) || (op == remu_op) || (op == div_op) || (op == rem_op);
  endfunction

endpackage

//--- src/decode_if.sv
// decode_if: one decoded instruction passed from the decoder to the execution units
`timescale 1ns/1ns

interface decode_if
  import rv_pkg::*;
();

  op_e      op;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  // sign-extended I immediate, or the upper immediate for lui
  word_t    imm;
  logic     use_imm;

  modport producer (output op, rd, rs1, rs2, imm, use_imm);
  modport consumer (input op, rd, rs1, rs2, imm, use_imm);

endinterface

//--- src/insn_decoder.sv
// insn_decoder: splits an RV32 instruction word into fields and selects the operation
`timescale 1ns/1ns

module insn_decoder
  import rv_pkg::*;
(
  input  word_t      i_insn,
  decode_if.producer dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  op_e        sel;

  assign opcode = i_insn[6:0];
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];

  assign dec.rd  = i_insn[11:7];
  assign dec.rs1 = i_insn[19:15];
  assign dec.rs2 = i_insn[24:20];
  assign dec.op  = sel;

  assign dec.imm = (opcode == op_lui) ? {i_insn[31:12], 12'b0}
                                      : {{20{i_insn[31]}}, i_insn[31:20]};

  // divides always take rs2 as the divisor
  assign dec.use_imm = !op_is_div(sel) && ((opcode == op_reg_imm) || (opcode == op_lui));

  always_comb begin
    sel = none_op;
    case (opcode)
      op_lui: sel = lui_op;
      op_environ: begin
        // ecall only, every other field must be zero
        if (i_insn[31:7] == '0) sel = ecall_op;
      end
      op_reg_imm: begin
        case (funct3)
          f3_add:  sel = add_op;
          f3_slt:  sel = slt_op;
          f3_sltu: sel = sltu_op;
          f3_xor:  sel = xor_op;
          f3_or:   sel = or_op;
          f3_and:  sel = and_op;
          f3_sll:  if (funct7 == f7_base) sel = sll_op;
          f3_sr: begin
            if (funct7 == f7_base) sel = srl_op;
            else if (funct7 == f7_alt) sel = sra_op;
          end
        endcase
      end
      op_reg_reg: begin
        if (funct7 == f7_base) begin
          case (funct3)
            f3_add:  sel = add_op;
            f3_sll:  sel = sll_op;
            f3_slt:  sel = slt_op;
            f3_sltu: sel = sltu_op;
            f3_xor:  sel = xor_op;
            f3_sr:   sel = srl_op;
            f3_or:   sel = or_op;
            f3_and:  sel = and_op;
          endcase
        end else if (funct7 == f7_alt) begin
          if (funct3 == f3_add) sel = sub_op;
          else if (funct3 == f3_sr) sel = sra_op;
        end else if (funct7 == f7_muldiv) begin
          // multiplies fall through to none
          case (funct3)
            f3_div:  sel = div_op;
            f3_divu: sel = divu_op;
            f3_rem:  sel = rem_op;
            f3_remu: sel = remu_op;
            default: sel = none_op;
          endcase
        end
      end
      default: sel = none_op;
    endcase
  end

endmodule

//--- src/reg_file.sv
// reg_file: 32 integer registers with two combinational read ports, x0 reads as zero
`timescale 1ns/1ns

module reg_file
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     i_we,
  input  reg_idx_t i_rd,
  input  word_t    i_rd_data,
  input  reg_idx_t i_rs1,
  input  reg_idx_t i_rs2,
  output word_t    o_rs1_data,
  output word_t    o_rs2_data
);

  word_t regs [32];

  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin
      // x0 is never written so it stays zero
      regs[i_rd] <= i_rd_data;
    end
  end

endmodule

//--- src/int_alu.sv
// int_alu: single-cycle result for every non-divide integer operation
`timescale 1ns/1ns

module int_alu
  import rv_pkg::*;
(
  decode_if.consumer dec,
  input  word_t      i_rs1_data,
  input  word_t      i_rs2_data,
  output word_t      o_result
);

  word_t      opnd_b;
  logic [4:0] shamt;

  // immediate group and lui use the decoded immediate
  assign opnd_b = dec.use_imm ? dec.imm : i_rs2_data;
  assign shamt  = opnd_b[4:0];

  always_comb begin
    case (dec.op)
      add_op:  o_result = i_rs1_data + opnd_b;
      sub_op:  o_result = i_rs1_data - opnd_b;
      sll_op:  o_result = i_rs1_data << shamt;
      slt_op:  o_result = {{(xlen-1){1'b0}}, $signed(i_rs1_data) < $signed(opnd_b)};
      sltu_op: o_result = {{(xlen-1){1'b0}}, i_rs1_data < opnd_b};
      xor_op:  o_result = i_rs1_data ^ opnd_b;
      srl_op:  o_result = i_rs1_data >> shamt;
      sra_op:  o_result = word_t'($signed(i_rs1_data) >>> shamt);
      or_op:   o_result = i_rs1_data | opnd_b;
      and_op:  o_result = i_rs1_data & opnd_b;
      lui_op:  o_result = dec.imm;
      // divides, ecall and unknown encodings produce nothing here
      default: o_result = '0;
    endcase
  end

endmodule

//--- src/div_unit.sv
// div_unit: iterative restoring divider for divu, remu, div and rem
`timescale 1ns/1ns

module div_unit
  import rv_pkg::*;
#(
  parameter int div_bits_per_cycle = 4
) (
  input  logic       clk,
  input  logic       rst,
  decode_if.consumer dec,
  input  logic       i_start,
  input  word_t      i_rs1_data,
  input  word_t      i_rs2_data,
  output logic       o_done,
  output word_t      o_result
);

  localparam int steps = xlen / div_bits_per_cycle;
  localparam int cnt_w = (steps > 1) ? $clog2(steps) : 1;
  localparam logic [cnt_w-1:0] last_count = cnt_w'(steps - 1);

  logic             busy_q;
  logic [cnt_w-1:0] count_q;

  // working state: partial remainder, dividend bits shifting out and quotient shifting in
  word_t rem_q;
  word_t dvd_q;
  word_t dvs_q;
  logic  neg_quo_q;
  logic  neg_rem_q;
  logic  want_rem_q;

  logic  is_signed;
  logic  a_neg;
  logic  b_neg;
  word_t step_rem;
  word_t step_dvd;
  logic [xlen:0] shifted;

  assign is_signed = (dec.op == div_op) || (dec.op == rem_op);
  assign a_neg     = is_signed && i_rs1_data[xlen-1];
  assign b_neg     = is_signed && i_rs2_data[xlen-1];

  // div_bits_per_cycle restoring steps per clock
  always_comb begin
    step_rem = rem_q;
    step_dvd = dvd_q;
    shifted  = '0;
    for (int i = 0; i < div_bits_per_cycle; i++) begin
      shifted  = {step_rem, step_dvd[xlen-1]};
      step_dvd = {step_dvd[xlen-2:0], 1'b0};
      if (shifted >= {1'b0, dvs_q}) begin
        shifted     = shifted - {1'b0, dvs_q};
        step_dvd[0] = 1'b1;
      end
      step_rem = shifted[xlen-1:0];
    end
  end

  // the last step is taken combinationally, so the result shows with o_done
  assign o_done = busy_q && (count_q == last_count);

  always_comb begin
    if (want_rem_q) begin
      o_result = neg_rem_q ? -step_rem : step_rem;
    end else begin
      o_result = neg_quo_q ? -step_dvd : step_dvd;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      count_q <= '0;
    end else if (i_start) begin
      busy_q  <= 1'b1;
      count_q <= '0;
    end else if (o_done) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      count_q <= count_q + cnt_w'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (i_start) begin
      rem_q      <= '0;
      dvd_q      <= a_neg ? -i_rs1_data : i_rs1_data;
      dvs_q      <= b_neg ? -i_rs2_data : i_rs2_data;
      // a zero divisor leaves the all-ones quotient unsigned
      neg_quo_q  <= (a_neg ^ b_neg) && (i_rs2_data != '0);
      neg_rem_q  <= a_neg;
      want_rem_q <= (dec.op == rem_op) || (dec.op == remu_op);
    end else if (busy_q) begin
      rem_q <= step_rem;
      dvd_q <= step_dvd;
    end
  end

endmodule

//--- src/exec_control.sv
// exec_control: program counter, divide stall, halt and write-back selection
`timescale 1ns/1ns

module exec_control
  import rv_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  decode_if.consumer dec,
  input  word_t      i_alu_result,
  input  logic       i_div_done,
  input  word_t      i_div_result,
  output logic       o_div_start,
  output word_t      o_fetch_pc,
  output logic       o_we,
  output logic       o_retire_valid,
  output reg_idx_t   o_retire_rd,
  output word_t      o_retire_data,
  output logic       o_halt
);

  // pc_q is the address of the instruction currently on the fetch input
  word_t pc_q;
  logic  run_q;
  logic  halt_q;
  logic  div_busy_q;

  logic  active;
  logic  is_div;
  logic  is_ecall;
  logic  div_finish;
  logic  wait_div;
  logic  advance;

  // first cycle after reset is a fetch bubble
  assign active     = run_q && !halt_q;
  assign is_div     = op_is_div(dec.op);
  assign is_ecall   = (dec.op == ecall_op);
  assign div_finish = div_busy_q && i_div_done;
  assign wait_div   = is_div && !div_finish;
  assign advance    = active && !is_ecall && !wait_div;

  assign o_div_start = active && is_div && !div_busy_q;

  // repeat the current address while stalled so the same word comes back
  assign o_fetch_pc = advance ? pc_q + 32'd4 : pc_q;

  assign o_retire_valid = active && (dec.op != none_op) && !is_ecall && !wait_div;
  assign o_we           = o_retire_valid && (dec.rd != '0);
  assign o_retire_rd    = dec.rd;
  assign o_retire_data  = (dec.rd == '0) ? '0 : (is_div ? i_div_result : i_alu_result);
  assign o_halt         = halt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q       <= '0;
      run_q      <= 1'b0;
      halt_q     <= 1'b0;
      div_busy_q <= 1'b0;
    end else begin
      pc_q  <= o_fetch_pc;
      run_q <= 1'b1;
      // halt is sticky until reset
      if (active && is_ecall) begin
        halt_q <= 1'b1;
      end
      if (o_div_start) begin
        div_busy_q <= 1'b1;
      end else if (i_div_done) begin
        div_busy_q <= 1'b0;
      end
    end
  end

endmodule

//--- src/rv_core.sv
// rv_core: RV32 integer execution core with an iterative divider
`timescale 1ns/1ns

module rv_core
  import rv_pkg::*;
#(
  parameter int div_bits_per_cycle = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  word_t    i_insn,
  output word_t    o_fetch_pc,
  output logic     o_retire_valid,
  output reg_idx_t o_retire_rd,
  output word_t    o_retire_data,
  output logic     o_halt
);

  decode_if dec_bus ();

  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  word_t div_result;
  logic  div_start;
  logic  div_done;
  logic  rf_we;

  insn_decoder decoder_i (
    .i_insn (i_insn),
    .dec    (dec_bus.producer)
  );

  reg_file reg_file_i (
    .clk        (clk),
    .rst        (rst),
    .i_we       (rf_we),
    .i_rd       (o_retire_rd),
    .i_rd_data  (o_retire_data),
    .i_rs1      (dec_bus.rs1),
    .i_rs2      (dec_bus.rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  int_alu alu_i (
    .dec        (dec_bus.consumer),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_result   (alu_result)
  );

  div_unit #(
    .div_bits_per_cycle (div_bits_per_cycle)
  ) div_i (
    .clk        (clk),
    .rst        (rst),
    .dec        (dec_bus.consumer),
    .i_start    (div_start),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_done     (div_done),
    .o_result   (div_result)
  );

  exec_control control_i (
    .clk            (clk),
    .rst            (rst),
    .dec            (dec_bus.consumer),
    .i_alu_result   (alu_result),
    .i_div_done     (div_done),
    .i_div_result   (div_result),
    .o_div_start    (div_start),
    .o_fetch_pc     (o_fetch_pc),
    .o_we           (rf_we),
    .o_retire_valid (o_retire_valid),
    .o_retire_rd    (o_retire_rd),
    .o_retire_data  (o_retire_data),
    .o_halt         (o_halt)
  );

endmodule

//--- verification/rv_core_tb.sv
// rv_core_tb: table-driven testbench that runs a small program and checks every retire
`timescale 1ns/1ns

module rv_core_tb;

  localparam int div_bpc = 4;
  localparam int div_steps = 32 / div_bpc;

  // divide kinds sit at the end of the list
  typedef enum int {
    t_add, t_sub, t_sll, t_slt, t_sltu, t_xor, t_srl, t_sra, t_or, t_and,
    t_divu, t_remu, t_div, t_rem
  } tb_op_e;

  logic        clk = 1'b0;
  logic        rst;
  // addi x0, x0, 0 until the fetch model takes over
  logic [31:0] i_insn = 32'h0000_0013;
  logic [31:0] o_fetch_pc;
  logic        o_retire_valid;
  logic [4:0]  o_retire_rd;
  logic [31:0] o_retire_data;
  logic        o_halt;

  // program rows with the retire each one must produce
  logic [31:0] prog [64];
  logic [4:0]  exp_rd [64];
  logic [31:0] exp_val [64];
  logic        row_div [64];
  logic        row_ecall [64];
  logic [31:0] mregs [32];
  int          n_rows;
  int          error_count;
  int          check_count;
  logic        table_ready;

  rv_core #(
    .div_bits_per_cycle (div_bpc)
  ) dut_i (
    .clk            (clk),
    .rst            (rst),
    .i_insn         (i_insn),
    .o_fetch_pc     (o_fetch_pc),
    .o_retire_valid (o_retire_valid),
    .o_retire_rd    (o_retire_rd),
    .o_retire_data  (o_retire_data),
    .o_halt         (o_halt)
  );

  always #50 clk = ~clk;

  // fetch model, the word for o_fetch_pc appears one cycle later
  always @(posedge clk) begin
    if (table_ready && (o_fetch_pc[31:2] < 30'(n_rows))) begin
      i_insn <= prog[o_fetch_pc[7:2]];
    end else begin
      i_insn <= 32'h0000_0013;
    end
  end

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // standard RV32 results, divide corners written out from the spec
  function automatic logic [31:0] model_op(tb_op_e op, logic [31:0] a, logic [31:0] b);
    logic overflow;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      t_add:  return a + b;
      t_sub:  return a - b;
      t_sll:  return a << b[4:0];
      t_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      t_sltu: return (a < b) ? 32'd1 : 32'd0;
      t_xor:  return a ^ b;
      t_srl:  return a >> b[4:0];
      t_sra:  return 32'($signed(a) >>> b[4:0]);
      t_or:   return a | b;
      t_and:  return a & b;
      t_divu: return (b == 32'd0) ? 32'hffff_ffff : a / b;
      t_remu: return (b == 32'd0) ? a : a % b;
      t_div: begin
        if (b == 32'd0) return 32'hffff_ffff;
        if (overflow) return a;
        return 32'($signed(a) / $signed(b));
      end
      t_rem: begin
        if (b == 32'd0) return a;
        if (overflow) return 32'd0;
        return 32'($signed(a) % $signed(b));
      end
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] encode_rr(tb_op_e op, logic [4:0] rd, logic [4:0] rs1,
                                            logic [4:0] rs2);
    logic [9:0] f;
    case (op)
      t_sub:  f = {7'h20, 3'd0};
      t_sll:  f = {7'h00, 3'd1};
      t_slt:  f = {7'h00, 3'd2};
      t_sltu: f = {7'h00, 3'd3};
      t_xor:  f = {7'h00, 3'd4};
      t_srl:  f = {7'h00, 3'd5};
      t_sra:  f = {7'h20, 3'd5};
      t_or:   f = {7'h00, 3'd6};
      t_and:  f = {7'h00, 3'd7};
      t_div:  f = {7'h01, 3'd4};
      t_divu: f = {7'h01, 3'd5};
      t_rem:  f = {7'h01, 3'd6};
      t_remu: f = {7'h01, 3'd7};
      default: f = {7'h00, 3'd0};
    endcase
    return {f[9:3], rs2, rs1, f[2:0], rd, 7'h33};
  endfunction

  function automatic logic [31:0] encode_ri(tb_op_e op, logic [4:0] rd, logic [4:0] rs1,
                                            logic [11:0] imm);
    logic [2:0]  f3;
    logic [11:0] field;
    field = imm;
    case (op)
      t_slt:  f3 = 3'd2;
      t_sltu: f3 = 3'd3;
      t_xor:  f3 = 3'd4;
      t_or:   f3 = 3'd6;
      t_and:  f3 = 3'd7;
      t_sll: begin
        f3 = 3'd1;
        field = {7'h00, imm[4:0]};
      end
      t_srl: begin
        f3 = 3'd5;
        field = {7'h00, imm[4:0]};
      end
      t_sra: begin
        f3 = 3'd5;
        field = {7'h20, imm[4:0]};
      end
      default: f3 = 3'd0;
    endcase
    return {field, rs1, f3, rd, 7'h13};
  endfunction

  task automatic push_row(logic [31:0] insn, logic [4:0] rd, logic [31:0] value,
                          logic is_div, logic is_ecall);
    prog[n_rows] = insn;
    exp_rd[n_rows] = rd;
    exp_val[n_rows] = (rd == 5'd0) ? 32'd0 : value;
    row_div[n_rows] = is_div;
    row_ecall[n_rows] = is_ecall;
    if (rd != 5'd0) mregs[rd] = value;
    n_rows++;
  endtask

  task automatic append_rr(tb_op_e op, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    push_row(encode_rr(op, rd, rs1, rs2), rd, model_op(op, mregs[rs1], mregs[rs2]),
             op >= t_divu, 1'b0);
  endtask

  task automatic append_ri(tb_op_e op, logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    logic [31:0] insn;
    logic [31:0] b;
    insn = encode_ri(op, rd, rs1, imm);
    b = {{20{insn[31]}}, insn[31:20]};
    push_row(insn, rd, model_op(op, mregs[rs1], b), 1'b0, 1'b0);
  endtask

  task automatic load_const(logic [4:0] rd, logic [31:0] value);
    logic [19:0] upper;
    // addi sign-extends its immediate so the upper part rounds up when bit 11 is set
    upper = value[31:12] + 20'(value[11]);
    push_row({upper, rd, 7'h37}, rd, {upper, 12'h000}, 1'b0, 1'b0);
    append_ri(t_add, rd, rd, value[11:0]);
  endtask

  task automatic build_program();
    logic [31:0] small_neg;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = 32'd0;
    end
    small_neg = -(($urandom() % 32'd4096) + 32'd3);
    load_const(5'd1, $urandom());
    load_const(5'd2, $urandom());
    load_const(5'd3, 32'h8000_0000);
    load_const(5'd4, 32'hffff_ffff);
    load_const(5'd5, small_neg);
    load_const(5'd6, 32'd0);
    for (int k = int'(t_add); k <= int'(t_and); k++) begin
      append_rr(tb_op_e'(k), 5'(7 + k), 5'd1, 5'd2);
    end
    append_ri(t_add, 5'd17, 5'd1, 12'($urandom()));
    append_ri(t_slt, 5'd18, 5'd2, 12'($urandom()));
    append_ri(t_sltu, 5'd19, 5'd1, 12'($urandom()));
    append_ri(t_xor, 5'd20, 5'd2, 12'($urandom()));
    append_ri(t_or, 5'd21, 5'd1, 12'($urandom()));
    append_ri(t_and, 5'd22, 5'd2, 12'($urandom()));
    append_ri(t_sll, 5'd23, 5'd1, 12'($urandom()));
    append_ri(t_srl, 5'd24, 5'd2, 12'($urandom()));
    append_ri(t_sra, 5'd25, 5'd3, 12'($urandom()));
    // x0 as a destination, then as a source
    append_rr(t_add, 5'd0, 5'd1, 5'd2);
    append_rr(t_add, 5'd26, 5'd0, 5'd1);
    append_rr(t_divu, 5'd27, 5'd1, 5'd2);
    append_rr(t_remu, 5'd28, 5'd1, 5'd2);
    append_rr(t_div, 5'd29, 5'd1, 5'd5);
    append_rr(t_rem, 5'd30, 5'd1, 5'd5);
    append_rr(t_div, 5'd27, 5'd2, 5'd1);
    append_rr(t_rem, 5'd28, 5'd2, 5'd1);
    // zero divisor and the signed overflow case
    append_rr(t_divu, 5'd7, 5'd1, 5'd6);
    append_rr(t_remu, 5'd8, 5'd1, 5'd6);
    append_rr(t_div, 5'd9, 5'd2, 5'd6);
    append_rr(t_rem, 5'd10, 5'd2, 5'd6);
    append_rr(t_div, 5'd11, 5'd3, 5'd4);
    append_rr(t_rem, 5'd12, 5'd3, 5'd4);
    push_row(32'h0000_0073, 5'd0, 32'd0, 1'b0, 1'b1);
  endtask

  initial begin
    int stalls;
    rst <= 1'b1;
    error_count = 0;
    check_count = 0;
    n_rows = 0;
    table_ready = 1'b0;
    void'($urandom(32'h7c67_c8a9));
    build_program();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // the first cycle out of reset is a fetch bubble
    @(posedge clk);
    for (int r = 0; r < n_rows; r++) begin
      stalls = 0;
      @(negedge clk);
      if (row_ecall[r]) begin
        check_value($sformatf("row %0d retire on ecall", r), 32'(o_retire_valid), 32'd0);
        check_value($sformatf("row %0d halt before ecall", r), 32'(o_halt), 32'd0);
        @(negedge clk);
        repeat (8) begin
          check_value("halt level", 32'(o_halt), 32'd1);
          check_value("retire after halt", 32'(o_retire_valid), 32'd0);
          check_value("fetch pc after halt", o_fetch_pc, 32'(r * 4));
          @(negedge clk);
        end
      end else begin
        while (!o_retire_valid) begin
          check_value($sformatf("row %0d fetch pc while stalled", r), o_fetch_pc, 32'(r * 4));
          stalls++;
          @(negedge clk);
        end
        check_value($sformatf("row %0d retire rd", r), 32'(o_retire_rd), 32'(exp_rd[r]));
        check_value($sformatf("row %0d retire data", r), o_retire_data, exp_val[r]);
        check_value($sformatf("row %0d stall cycles", r), 32'(stalls),
                    row_div[r] ? 32'(div_steps) : 32'd0);
        check_value($sformatf("row %0d next fetch pc", r), o_fetch_pc, 32'((r + 1) * 4));
      end
    end
    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog sized from the program length and the divide latency
  initial begin
    int limit;
    wait (table_ready);
    limit = n_rows * (div_steps + 2) + 40;
    repeat (limit) @(posedge clk);
    $display("timeout: the program did not finish within %0d cycles", limit);
    $display("test failed");
    $finish;
  end

endmodule

//--- compile.f
src/rv_pkg.sv
src/decode_if.sv
src/insn_decoder.sv
src/reg_file.sv
src/int_alu.sv
src/div_unit.sv
src/exec_control.sv
src/rv_core.sv
verification/rv_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f compile.f --top-module rv_core_tb \
  -Mdir obj_dir -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" sim.log; then
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  echo "simulation log has no pass line"
  exit 1
fi
exit 0
